// File: build.f
+incdir+rtl
rtl/cross_pkg.sv
rtl/job_if.sv
rtl/vec_fifo.sv
rtl/mul_pipe.sv
rtl/cross_product_core.sv
rtl/cross_wb_regs.sv
rtl/cross_accel_top.sv
test/tb_cross_accel.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_cross_accel -f build.f -o sim_cross

./obj_dir/sim_cross > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: test/tb_cross_accel.sv
`timescale 1ns/10ps
`include "cross_settings.svh"

module tb_cross_accel;

  localparam int N_JOBS       = 18;                   // 1 known + 10 fill/drain + 7 full range
  localparam int WATCHDOG_CYC = 200 * N_JOBS + 2000;
  localparam int POLL_LIMIT   = 64;                   // STATUS reads before a result counts lost
  localparam logic [3:0] HOLES [6] = '{4'd6, 4'd7, 4'd11, 4'd13, 4'd14, 4'd15};  // read as 0

  logic        clk = 1'b0;
  logic        rst;
  logic        wb_cyc, wb_stb, wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int          errors = 0;
  int          checks = 0;
  logic [95:0] exp_q [$];    // expected {z, y, x} in issue order
  logic [95:0] pending_exp;  // result of the operands now in A and B

  cross_accel_top DUT (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  always #2 clk = ~clk;  // 4 ns period

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else begin
      errors++;
      $display("[ERROR] %0t wb_ack stayed high for more than one cycle", $time);
    end

  ack_in_access: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
    else begin
      errors++;
      $display("[ERROR] %0t wb_ack came outside an access with cyc and stb", $time);
    end

  // cross product, int math wraps at 32 bits
  function automatic logic [95:0] cross_ref(input int ax, ay, az, bx, by, bz);
    int rx, ry, rz;
    rx = ay * bz - az * by;
    ry = az * bx - ax * bz;
    rz = ax * by - ay * bx;
    return {rz, ry, rx};
  endfunction

  function automatic int rand_comp();
    if ($urandom_range(3, 0) == 0) return int'(32'h8000_0000);  // most negative, often
    return int'($urandom);
  endfunction

  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk);
    while (wb_ack !== 1'b1) @(negedge clk);  // watchdog bounds a missing ack
    rdata = wb_dat_r;                        // valid while ack is high
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    logic [31:0] ignored;
    bus_access(1'b1, adr, dat, ignored);
  endtask

  task automatic check_read(input logic [3:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    bus_access(1'b0, adr, 32'h0, got);
    checks++;
    rd_match: assert (got === exp)
      else begin
        errors++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      end
  endtask

  task automatic load_job(input int ax, ay, az, bx, by, bz);
    wb_write(`CROSS_ADR_A, ax);
    wb_write(`CROSS_ADR_A + 4'd1, ay);
    wb_write(`CROSS_ADR_A + 4'd2, az);
    wb_write(`CROSS_ADR_B, bx);
    wb_write(`CROSS_ADR_B + 4'd1, by);
    wb_write(`CROSS_ADR_B + 4'd2, bz);
    pending_exp = cross_ref(ax, ay, az, bx, by, bz);
  endtask

  task automatic issue_go();
    wb_write(`CROSS_ADR_GO, 32'h1);
    exp_q.push_back(pending_exp);  // queued once acked
  endtask

  task automatic wait_result();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (st[`CROSS_STATUS_RES] !== 1'b1 && polls < POLL_LIMIT) begin
      bus_access(1'b0, `CROSS_ADR_STATUS, 32'h0, st);
      polls++;
    end
    checks++;
    res_seen: assert (st[`CROSS_STATUS_RES] === 1'b1)
      else begin
        errors++;
        $display("[ERROR] %0t no result showed up after %0d STATUS reads", $time, polls);
      end
  endtask

  task automatic pop_and_check();
    logic [95:0] exp;
    exp = exp_q.pop_front();
    check_read(`CROSS_ADR_RES, exp[31:0], "wb_dat_r@RES.x");
    check_read(`CROSS_ADR_RES + 4'd1, exp[63:32], "wb_dat_r@RES.y");
    check_read(`CROSS_ADR_RES + 4'd2, exp[95:64], "wb_dat_r@RES.z");
    wb_write(`CROSS_ADR_POP, 32'h0);
  endtask

  // GO against a full job FIFO, withdrawn after some cycles without ack
  task automatic go_blocked(input int cycles);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b1;
    wb_adr <= `CROSS_ADR_GO;
    repeat (cycles) begin
      @(negedge clk);
      checks++;
      go_held: assert (wb_ack === 1'b0)
        else begin
          errors++;
          $display("[ERROR] %0t wb_ack expected 0 got %b with job FIFO full", $time, wb_ack);
        end
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  initial begin
    void'($urandom(14789));
    rst      <= 1'b1;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);  // idle state after reset
    checks++;
    ack_idle: assert (wb_ack === 1'b0)
      else begin
        errors++;
        $display("[ERROR] %0t wb_ack expected 0 got %b after reset", $time, wb_ack);
      end
    check_read(`CROSS_ADR_STATUS, 32'h0, "wb_dat_r@STATUS");
    for (int i = 0; i < 3; i++) check_read(4'(`CROSS_ADR_RES + i), 32'h0, "wb_dat_r@RES");

    for (int i = 0; i < 3; i++) begin  // operand readback
      wb_write(4'(`CROSS_ADR_A + i), 32'h1111_0000 + i);
      wb_write(4'(`CROSS_ADR_B + i), 32'hfeed_0000 + i);
    end
    for (int i = 0; i < 3; i++) begin
      check_read(4'(`CROSS_ADR_A + i), 32'h1111_0000 + i, "wb_dat_r@A");
      check_read(4'(`CROSS_ADR_B + i), 32'hfeed_0000 + i, "wb_dat_r@B");
    end
    foreach (HOLES[i]) check_read(HOLES[i], 32'h0, "wb_dat_r@unmapped");

    load_job(1, 2, 3, 4, 5, 6);  // small known job
    issue_go();
    wait_result();
    pop_and_check();
    check_read(`CROSS_ADR_STATUS, 32'h0, "wb_dat_r@STATUS");

    // 4 in result FIFO, 1 frozen in the core, 4 in the job FIFO
    repeat (9) begin
      load_job($urandom, $urandom, $urandom, $urandom, $urandom, $urandom);
      issue_go();
    end
    check_read(`CROSS_ADR_STATUS, 32'h3, "wb_dat_r@STATUS");
    go_blocked(16);
    wait_result();
    pop_and_check();  // frees a slot down the chain
    issue_go();       // same operands again, now accepted
    while (exp_q.size() > 0) begin
      wait_result();
      pop_and_check();
    end
    check_read(`CROSS_ADR_STATUS, 32'h0, "wb_dat_r@STATUS");

    load_job(int'(32'h8000_0000), 32'h7fff_ffff, -1, int'(32'h8000_0000), 2, int'(32'h8000_0000));
    issue_go();
    wait_result();
    pop_and_check();
    repeat (6) begin  // full range, wrap-around
      load_job(rand_comp(), rand_comp(), rand_comp(), rand_comp(), rand_comp(), rand_comp());
      issue_go();
      wait_result();
      pop_and_check();
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYC);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: rtl/cross_accel_top.sv
`timescale 1ns/10ps
`include "cross_settings.svh"

module cross_accel_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic                        job_valid, job_ready;
  logic [cross_pkg::JOB_W-1:0] job_data;
  logic [cross_pkg::JOB_W-1:0] job_head;   // FIFO head, split onto the bus
  logic                        res_valid, res_ready;
  cross_pkg::vec3_u            res_data;
  logic                        out_valid, out_ready;
  cross_pkg::vec3_u            out_data;

  job_if job_bus ();

  assign job_bus.a = job_head[cross_pkg::VEC_W-1:0];               // A low
  assign job_bus.b = job_head[cross_pkg::JOB_W-1:cross_pkg::VEC_W];  // B high

  cross_wb_regs u_regs (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .job_valid, .job_ready, .job_data, .out_valid, .out_ready, .out_data
  );

  vec_fifo #(.WIDTH(cross_pkg::JOB_W), .DEPTH(`CROSS_JOB_DEPTH)) u_job_fifo (
    .clk, .rst, .in_valid(job_valid), .in_ready(job_ready), .in_data(job_data),
    .out_valid(job_bus.valid), .out_ready(job_bus.ready), .out_data(job_head)
  );

  cross_product_core u_core (.clk, .rst, .job(job_bus), .res_valid, .res_ready, .res_data);

  vec_fifo #(.WIDTH(cross_pkg::VEC_W), .DEPTH(`CROSS_RES_DEPTH)) u_res_fifo (
    .clk, .rst, .in_valid(res_valid), .in_ready(res_ready), .in_data(res_data),
    .out_valid, .out_ready, .out_data
  );

endmodule

// File: rtl/cross_wb_regs.sv
`timescale 1ns/10ps
`include "cross_settings.svh"

module cross_wb_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [3:0]                   wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic [31:0]                  wb_dat_r,
  output logic                         wb_ack,
  output logic                         job_valid,
  input  logic                         job_ready,
  output logic [cross_pkg::JOB_W-1:0]  job_data,
  input  logic                         out_valid,
  output logic                         out_ready,
  input  cross_pkg::vec3_u             out_data
);

  cross_pkg::vec3_u op_a, op_b;  // operand registers
  logic             req;         // access not yet acked
  logic             go_wr;
  logic [31:0]      status;
  logic [31:0]      rd_word;

  // ack gates req so a held strobe is not seen twice
  assign req   = wb_cyc & wb_stb & ~wb_ack;
  assign go_wr = req & wb_we & (wb_adr == `CROSS_ADR_GO);

  assign job_valid = go_wr;                     // offered until the FIFO takes it
  assign job_data  = {op_b.raw, op_a.raw};
  assign out_ready = req & wb_we & (wb_adr == `CROSS_ADR_POP) & out_valid;  // empty pop ignored

  always_comb begin
    status = '0;
    status[`CROSS_STATUS_RES]  = out_valid;
    status[`CROSS_STATUS_FULL] = ~job_ready;   // FIFO full shows as not ready
  end

  always_comb begin
    case (wb_adr)
      `CROSS_ADR_A:           rd_word = op_a.comp.x;
      `CROSS_ADR_A + 4'd1:    rd_word = op_a.comp.y;
      `CROSS_ADR_A + 4'd2:    rd_word = op_a.comp.z;
      `CROSS_ADR_B:           rd_word = op_b.comp.x;
      `CROSS_ADR_B + 4'd1:    rd_word = op_b.comp.y;
      `CROSS_ADR_B + 4'd2:    rd_word = op_b.comp.z;
      `CROSS_ADR_RES:         rd_word = out_valid ? out_data.comp.x : '0;  // empty reads 0
      `CROSS_ADR_RES + 4'd1:  rd_word = out_valid ? out_data.comp.y : '0;
      `CROSS_ADR_RES + 4'd2:  rd_word = out_valid ? out_data.comp.z : '0;
      `CROSS_ADR_STATUS:      rd_word = status;
      default:                rd_word = '0;                               // GO, POP, holes
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_a <= '0;
      op_b <= '0;
    end else if (req && wb_we) begin
      case (wb_adr)
        `CROSS_ADR_A:        op_a.comp.x <= wb_dat_w;
        `CROSS_ADR_A + 4'd1: op_a.comp.y <= wb_dat_w;
        `CROSS_ADR_A + 4'd2: op_a.comp.z <= wb_dat_w;
        `CROSS_ADR_B:        op_b.comp.x <= wb_dat_w;
        `CROSS_ADR_B + 4'd1: op_b.comp.y <= wb_dat_w;
        `CROSS_ADR_B + 4'd2: op_b.comp.z <= wb_dat_w;
        default: ;                                    // read-only or unmapped
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      wb_ack   <= req & (~go_wr | job_ready);   // GO waits for its FIFO slot
      wb_dat_r <= (req && !wb_we) ? rd_word : '0;
    end
  end

  // ack belongs to the access still held by the master
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: rtl/cross_product_core.sv
`timescale 1ns/10ps
`include "cross_settings.svh"

module cross_product_core (
  input  logic             clk,
  input  logic             rst,
  job_if.snk               job,
  output logic             res_valid,
  input  logic             res_ready,
  output cross_pkg::vec3_u res_data
);

  localparam int LAT = `CROSS_MUL_LATENCY + `CROSS_SUB_LATENCY;  // 3 clocks

  logic             en;        // one advance for the whole pipe
  logic             accept;
  logic [LAT-1:0]   vld;       // valid bit per stage, follows the data
  cross_pkg::comp_t op_a [6];  // multiplier inputs
  cross_pkg::comp_t op_b [6];
  cross_pkg::comp_t prod [6];
  cross_pkg::vec3_u diff;
  cross_pkg::vec3_u sub_q [`CROSS_SUB_LATENCY];

  // freeze everything while a finished result waits downstream
  assign en        = ~(vld[LAT-1] & ~res_ready);
  assign job.ready = en;
  assign accept    = job.valid & en;

  // operand pairs: even index is the minuend product
  always_comb begin
    op_a[0] = job.a.comp.y;  op_b[0] = job.b.comp.z;  // x: ay*bz
    op_a[1] = job.a.comp.z;  op_b[1] = job.b.comp.y;  //    - az*by
    op_a[2] = job.a.comp.z;  op_b[2] = job.b.comp.x;  // y: az*bx
    op_a[3] = job.a.comp.x;  op_b[3] = job.b.comp.z;  //    - ax*bz
    op_a[4] = job.a.comp.x;  op_b[4] = job.b.comp.y;  // z: ax*by
    op_a[5] = job.a.comp.y;  op_b[5] = job.b.comp.x;  //    - ay*bx
  end

  for (genvar i = 0; i < 6; i++) begin : g_mul
    mul_pipe #(
      .STAGES (`CROSS_MUL_LATENCY)
    ) u_mul (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .a   (op_a[i]),
      .b   (op_b[i]),
      .p   (prod[i])
    );
  end

  assign diff.comp.x = prod[0] - prod[1];  // wraps like the products
  assign diff.comp.y = prod[2] - prod[3];
  assign diff.comp.z = prod[4] - prod[5];

  always_ff @(posedge clk) begin
    if (en) begin
      sub_q[0] <= diff;
      for (int i = 1; i < `CROSS_SUB_LATENCY; i++) sub_q[i] <= sub_q[i-1];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) vld <= '0;
    else if (en) vld <= {vld[LAT-2:0], accept};  // jobs overlap, one per stage
  end

  assign res_valid = vld[LAT-1];
  assign res_data  = sub_q[`CROSS_SUB_LATENCY-1];

  // a stalled result must not move or vanish
  a_res_hold: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res_data));

  // enable low freezes the valid bits and every multiplier stage
  a_frozen: assert property (@(posedge clk) disable iff (rst)
    !en |=> $stable(vld) && $stable(diff));

endmodule

// File: rtl/mul_pipe.sv
`timescale 1ns/10ps

module mul_pipe #(
  parameter int STAGES = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,   // pipeline advance
  input  cross_pkg::comp_t a,
  input  cross_pkg::comp_t b,
  output cross_pkg::comp_t p     // a*b, low 32 bits, STAGES clocks later
);

  cross_pkg::comp_t prod;
  cross_pkg::comp_t stage_q [STAGES];

  assign prod = a * b;  // 32-bit context keeps only the wrapped low word

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < STAGES; i++) stage_q[i] <= '0;
    end else if (en) begin
      stage_q[0] <= prod;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];  // plain delay behind the multiply
      end
    end
  end

  assign p = stage_q[STAGES-1];

endmodule

// File: rtl/vec_fifo.sv
`timescale 1ns/10ps

module vec_fifo #(
  parameter int WIDTH = 96,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
  localparam int CW = $clog2(DEPTH + 1);                // count width

  logic [WIDTH-1:0] mem [DEPTH];  // storage, no reset
  logic [AW-1:0]    wr_ptr, rd_ptr;
  logic [CW-1:0]    count;         // entries held
  logic             push, pop;

  assign in_ready  = (count != CW'(DEPTH));  // full blocks the writer
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];            // head is read directly

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;  // both: count holds
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    count <= CW'(DEPTH));

  // pointers meet only when the buffer is empty or full
  a_ptr_count: assert property (@(posedge clk) disable iff (rst)
    (wr_ptr == rd_ptr) == (count == '0 || count == CW'(DEPTH)));

endmodule

// File: rtl/job_if.sv
`timescale 1ns/10ps

// one job: two operand vectors moving from the job FIFO into the core
interface job_if;

  logic              valid;  // a and b hold a job
  logic              ready;  // core takes the job this cycle
  cross_pkg::vec3_u  a;      // first operand
  cross_pkg::vec3_u  b;      // second operand

  // buffer side
  modport src (
    output valid, a, b,
    input  ready
  );

  // core side
  modport snk (
    input  valid, a, b,
    output ready
  );

endinterface

// File: rtl/cross_pkg.sv
package cross_pkg;

  // one vector component, two's complement, wraps on overflow
  typedef logic signed [31:0] comp_t;

  // component view of a vector word, x in the low word
  typedef struct packed {
    comp_t z;  // bits 95:64
    comp_t y;  // bits 63:32
    comp_t x;  // bits 31:0
  } vec3_t;

  // a vector word is moved around whole (raw) but built and read
  // per component (comp)
  typedef union packed {
    logic [95:0] raw;
    vec3_t       comp;
  } vec3_u;

  localparam int VEC_W = $bits(vec3_u);  // 96
  localparam int JOB_W = 2 * VEC_W;      // A and B together, B on top

endpackage

// File: rtl/cross_settings.svh
`ifndef CROSS_SETTINGS_SVH
`define CROSS_SETTINGS_SVH

// pipeline latencies of the cross-product core
`define CROSS_MUL_LATENCY 2   // multiplier register stages
`define CROSS_SUB_LATENCY 1   // subtract register stage

// buffer depths, powers of two
`define CROSS_JOB_DEPTH 4     // operand (job) FIFO entries
`define CROSS_RES_DEPTH 4     // result FIFO entries

// wishbone word address map, 4-bit address
`define CROSS_ADR_A      4'd0   // A.x, A.y, A.z at 0..2
`define CROSS_ADR_B      4'd3   // B.x, B.y, B.z at 3..5
`define CROSS_ADR_GO     4'd6   // write queues a job
`define CROSS_ADR_RES    4'd8   // result x, y, z at 8..10
`define CROSS_ADR_POP    4'd11  // write drops the result head
`define CROSS_ADR_STATUS 4'd12  // bit0 result ready, bit1 job FIFO full

`define CROSS_STATUS_RES  0     // status bit positions
`define CROSS_STATUS_FULL 1

`endif
